// ==== hw/mac_pkg.sv ====
package mac_pkg;

  // Datapath widths
  localparam int OPERAND_W  = 16;
  localparam int PROD_W     = 2 * OPERAND_W;
  localparam int ACC_W      = 40;
  localparam int CFG_W      = 16;

  // Result buffering and flow control
  localparam int FIFO_DEPTH = 8;
  localparam int PTR_W      = $clog2(FIFO_DEPTH);
  localparam int CREDIT_W   = 4;

  typedef logic signed [OPERAND_W-1:0] operand_t;
  typedef logic signed [PROD_W-1:0]    prod_t;
  typedef logic signed [ACC_W-1:0]     acc_t;
  typedef logic [CFG_W-1:0]            count_t;

  // One beat of the input stream
  typedef struct packed {
    operand_t a;
    operand_t b;
    logic     last;
  } in_beat_t;

  // Per-beat control for the MAC slice
  typedef struct packed {
    logic fire;
    logic restart;
    logic emit;
  } mac_ctrl_t;

  typedef enum logic {
    MODE_DOT     = 1'b0,
    MODE_PRODUCT = 1'b1
  } mac_mode_e;

  // Register map
  localparam logic [1:0] REG_CTRL  = 2'd0;
  localparam logic [1:0] REG_COUNT = 2'd1;

endpackage

// ==== hw/mac_cfg_regs.sv ====
`timescale 1ns/1ps

module mac_cfg_regs import mac_pkg::*; (
  input  logic             clk,
  input  logic             rst,

  // Config port
  input  logic             cfg_wr_en,
  input  logic [1:0]       cfg_addr,
  input  logic [CFG_W-1:0] cfg_wdata,
  output logic [CFG_W-1:0] cfg_rdata,

  // Status from the datapath
  input  logic             busy,
  input  logic             out_fire,

  // Control to the datapath
  output logic             enable,
  output mac_mode_e        mode
);

  count_t    delivered;
  logic      ctrl_wr;

  assign ctrl_wr = cfg_wr_en && (cfg_addr == REG_CTRL);

  // Control bits
  always_ff @(posedge clk) begin
    if (rst) begin
      enable <= 1'b0;
      mode   <= MODE_DOT;
    end else if (ctrl_wr) begin
      enable <= cfg_wdata[0];
      // Mode stays put while a vector is open
      if (!busy) begin
        mode <= mac_mode_e'(cfg_wdata[1]);
      end
    end
  end

  // Delivered results, wraps at 16 bits
  always_ff @(posedge clk) begin
    if (rst) begin
      delivered <= '0;
    end else if (out_fire) begin
      delivered <= delivered + 1'b1;
    end
  end

  // Read decode
  always_comb begin
    cfg_rdata = '0;
    case (cfg_addr)
      REG_CTRL: begin
        cfg_rdata[0] = enable;
        cfg_rdata[1] = mode;
      end
      REG_COUNT: begin
        cfg_rdata = delivered;
      end
      default: begin
        cfg_rdata = '0;
      end
    endcase
  end

endmodule

// ==== hw/mac_sequencer.sv ====
`timescale 1ns/1ps

module mac_sequencer import mac_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  // Configuration
  input  logic      enable,
  input  mac_mode_e mode,

  // Input stream
  input  logic      in_valid,
  input  in_beat_t  in_beat,
  output logic      in_ready,

  // Credit return from the result FIFO
  input  logic      pop,

  // Per-beat control and operands for the slice
  output mac_ctrl_t ctrl,
  output operand_t  op_a,
  output operand_t  op_b,

  output logic      busy
);

  logic [CREDIT_W-1:0] credits;
  logic                vec_open;
  logic                handshake;
  logic                take;
  logic                product_mode;

  assign product_mode = (mode == MODE_PRODUCT);

  // Room for at least one more result
  assign in_ready  = enable && (credits != '0);
  assign handshake = in_valid && in_ready;

  // Control for the slice in the handshake cycle
  always_comb begin
    ctrl.fire    = handshake;
    ctrl.restart = product_mode || !vec_open;
    ctrl.emit    = product_mode || in_beat.last;
  end

  assign op_a = in_beat.a;
  assign op_b = in_beat.b;

  // Only beats that emit a result use up a FIFO entry
  assign take = handshake && ctrl.emit;

  // Vector tracking
  // a vector stays open after a non-last beat in dot mode
  always_ff @(posedge clk) begin
    if (rst) begin
      vec_open <= 1'b0;
    end else if (handshake) begin
      vec_open <= !product_mode && !in_beat.last;
    end
  end

  assign busy = vec_open;

  // Free entries in the result FIFO
  always_ff @(posedge clk) begin
    if (rst) begin
      credits <= CREDIT_W'(FIFO_DEPTH);
    end else begin
      case ({take, pop})
        2'b10: begin
          credits <= credits - 1'b1;
        end
        2'b01: begin
          credits <= credits + 1'b1;
        end
        default: begin
          credits <= credits;
        end
      endcase
    end
  end

endmodule

// ==== hw/mac_dsp_slice.sv ====
`timescale 1ns/1ps

module mac_dsp_slice import mac_pkg::*; (
  input  logic      clk,
  input  logic      rst,

  // Beat in
  input  mac_ctrl_t ctrl,
  input  operand_t  op_a,
  input  operand_t  op_b,

  // Result out
  output logic      result_valid,
  output acc_t      result
);

  // Stage 0 operand registers
  operand_t  op_a_q;
  operand_t  op_b_q;

  // Stage 1 product register
  prod_t     prod_q;
  acc_t      prod_ext;

  // Stage 2 accumulator
  acc_t      acc_q;
  acc_t      acc_base;

  // Control delayed alongside the data
  mac_ctrl_t ctrl_q0;
  mac_ctrl_t ctrl_q1;

  // Stage clock enables
  logic      ce_in;
  logic      ce_mlt;
  logic      ce_acc;

  assign ce_in  = ctrl.fire;
  assign ce_mlt = ctrl_q0.fire;
  assign ce_acc = ctrl_q1.fire;

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_q0      <= '0;
      ctrl_q1      <= '0;
      result_valid <= 1'b0;
    end else begin
      ctrl_q0      <= ctrl;
      ctrl_q1      <= ctrl_q0;
      result_valid <= ctrl_q1.fire && ctrl_q1.emit;
    end
  end

  // Multiplier inputs
  always_ff @(posedge clk) begin
    if (ce_in) begin
      op_a_q <= op_a;
      op_b_q <= op_b;
    end
  end

  // Full-width signed product
  always_ff @(posedge clk) begin
    if (ce_mlt) begin
      prod_q <= op_a_q * op_b_q;
    end
  end

  assign prod_ext = {{(ACC_W - PROD_W){prod_q[PROD_W-1]}}, prod_q};

  // Restart loads the product, otherwise the old sum is kept
  always_comb begin
    if (ctrl_q1.restart) begin
      acc_base = '0;
    end else begin
      acc_base = acc_q;
    end
  end

  always_ff @(posedge clk) begin
    if (ce_acc) begin
      acc_q <= acc_base + prod_ext;
    end
  end

  assign result = acc_q;

endmodule

// ==== hw/result_fifo.sv ====
`timescale 1ns/1ps

module result_fifo import mac_pkg::*; (
  input  logic clk,
  input  logic rst,

  // Write side from the slice
  input  logic push,
  input  acc_t push_data,

  // Output stream
  output logic out_valid,
  output acc_t out_data,
  input  logic out_ready,

  // Output transfer, used for credits and the counter
  output logic pop
);

  acc_t                mem [FIFO_DEPTH];
  logic [PTR_W-1:0]    wr_ptr;
  logic [PTR_W-1:0]    rd_ptr;
  logic [CREDIT_W-1:0] count;

  assign out_valid = (count != '0);
  assign out_data  = mem[rd_ptr];
  assign pop       = out_valid && out_ready;

  // Storage
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // Occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

endmodule

// ==== hw/mac_stream_top.sv ====
`timescale 1ns/1ps

module mac_stream_top import mac_pkg::*; (
  input  logic             clk,
  input  logic             rst,

  // Config port
  input  logic             cfg_wr_en,
  input  logic [1:0]       cfg_addr,
  input  logic [CFG_W-1:0] cfg_wdata,
  output logic [CFG_W-1:0] cfg_rdata,

  // Input stream
  input  logic             in_valid,
  input  in_beat_t         in_beat,
  output logic             in_ready,

  // Output stream
  output logic             out_valid,
  output acc_t             out_data,
  input  logic             out_ready
);

  logic      enable;
  mac_mode_e mode;
  logic      busy;
  logic      pop;

  mac_ctrl_t ctrl;
  operand_t  op_a;
  operand_t  op_b;

  logic      result_valid;
  acc_t      result;

  mac_cfg_regs u_regs (
    .clk       (clk),
    .rst       (rst),
    .cfg_wr_en (cfg_wr_en),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .busy      (busy),
    .out_fire  (pop),
    .enable    (enable),
    .mode      (mode)
  );

  mac_sequencer u_seq (
    .clk      (clk),
    .rst      (rst),
    .enable   (enable),
    .mode     (mode),
    .in_valid (in_valid),
    .in_beat  (in_beat),
    .in_ready (in_ready),
    .pop      (pop),
    .ctrl     (ctrl),
    .op_a     (op_a),
    .op_b     (op_b),
    .busy     (busy)
  );

  mac_dsp_slice u_slice (
    .clk          (clk),
    .rst          (rst),
    .ctrl         (ctrl),
    .op_a         (op_a),
    .op_b         (op_b),
    .result_valid (result_valid),
    .result       (result)
  );

  // Results buffered until the consumer takes them
  result_fifo u_fifo (
    .clk       (clk),
    .rst       (rst),
    .push      (result_valid),
    .push_data (result),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready),
    .pop       (pop)
  );

endmodule

// ==== dv/mac_stream_props.sv ====
`timescale 1ns/1ps

module mac_stream_props import mac_pkg::*; (
  input logic                clk,
  input logic                rst,
  input logic                in_ready,
  input logic                out_valid,
  input logic                out_ready,
  input acc_t                out_data,
  input logic                push,
  input logic [CREDIT_W-1:0] fifo_count,
  input logic [CREDIT_W-1:0] credits
);

  // Number of failed properties so far
  int fail_count = 0;

  // Credit rule keeps a free slot for every result
  a_push_has_room: assert property (@(posedge clk) disable iff (rst)
      push |-> (fifo_count < CREDIT_W'(FIFO_DEPTH)))
    else begin
      fail_count++;
      $error("result pushed into a full FIFO");
    end

  // Head entry holds while the consumer stalls
  a_out_hold: assert property (@(posedge clk) disable iff (rst)
      (out_valid && !out_ready) |=> (out_valid && $stable(out_data)))
    else begin
      fail_count++;
      $error("output stream dropped or changed a stalled result");
    end

  // Free credits and stored results never add up past the depth
  a_credit_limit: assert property (@(posedge clk) disable iff (rst)
      (int'(credits) + int'(fifo_count)) <= FIFO_DEPTH)
    else begin
      fail_count++;
      $error("credits and stored results exceed the FIFO depth");
    end

  // Input closes while the FIFO is full
  a_full_blocks_input: assert property (@(posedge clk) disable iff (rst)
      (fifo_count == CREDIT_W'(FIFO_DEPTH)) |-> !in_ready)
    else begin
      fail_count++;
      $error("input ready while the FIFO is full");
    end

endmodule

bind mac_stream_top mac_stream_props u_props (
  .clk        (clk),
  .rst        (rst),
  .in_ready   (in_ready),
  .out_valid  (out_valid),
  .out_ready  (out_ready),
  .out_data   (out_data),
  .push       (result_valid),
  .fifo_count (u_fifo.count),
  .credits    (u_seq.credits)
);

// ==== dv/mac_stream_tb.sv ====
`timescale 1ns/1ps

module mac_stream_tb import mac_pkg::*; ();

  localparam int DRIVE_DELAY = 5;
  localparam int READY_DELAY = 10;
  localparam int DOT_VECTORS = 30;
  localparam int PROD_BEATS  = 60;
  localparam int BP_VECTORS  = 40;
  // Vectors hold at most 8 beats
  localparam int MAX_BEATS   = (DOT_VECTORS + BP_VECTORS) * 8 + PROD_BEATS + 16;
  localparam int CYCLE_LIMIT = MAX_BEATS * 12 + 2000;

  logic             clk;
  logic             rst;
  logic             cfg_wr_en;
  logic [1:0]       cfg_addr;
  logic [CFG_W-1:0] cfg_wdata;
  logic [CFG_W-1:0] cfg_rdata;
  logic             in_valid;
  in_beat_t         in_beat;
  logic             in_ready;
  logic             out_valid;
  acc_t             out_data;
  logic             out_ready;

  logic [31:0]      lfsr;
  int               ready_rate;   // 0 always ready, n ready 1 in 2**n, -1 stalled
  mac_mode_e        model_mode;
  logic             model_open;
  longint           model_acc;
  acc_t             exp_q[$];
  int               received;
  int               cycles;

  mac_stream_top UUT (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Operands lean on the ends of the signed range
  function automatic operand_t rand_operand();
    logic [1:0] kind;
    kind = 2'(rand_bits(2));
    if (kind == 2'd0) begin
      return operand_t'(16'h8000);
    end else if (kind == 2'd1) begin
      return operand_t'(16'h7fff);
    end
    return operand_t'(rand_bits(16));
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("TESTBENCH FAILED");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      report_failure($sformatf("mismatch %s: got %0h, expected %0h", name, got, exp));
    end
  endtask

  // One beat through the valid/ready handshake, then the model
  task automatic send_beat(input logic last);
    int     gap;
    longint prod;
    logic   product_mode;
    gap = (rand_bits(1) != 0) ? 0 : int'(rand_bits(2));
    repeat (gap) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
    in_beat.a    = rand_operand();
    in_beat.b    = rand_operand();
    in_beat.last = last;
    in_valid     = 1'b1;
    while (!in_ready) begin
      @(posedge clk);
      #DRIVE_DELAY;
    end
    @(posedge clk);
    #DRIVE_DELAY;
    in_valid = 1'b0;
    product_mode = (model_mode == MODE_PRODUCT);
    prod = longint'(in_beat.a) * longint'(in_beat.b);
    // Sum restarts on a vector's first beat and on every product beat
    model_acc = (product_mode || !model_open) ? prod : model_acc + prod;
    if (product_mode || in_beat.last) begin
      exp_q.push_back(acc_t'(model_acc));
    end
    model_open = !product_mode && !in_beat.last;
  endtask

  task automatic send_vector();
    int len;
    len = 1 + int'(rand_bits(3));
    for (int i = 1; i <= len; i++) begin
      send_beat(i == len);
    end
  endtask

  task automatic write_ctrl(input logic en, input mac_mode_e mode);
    cfg_wr_en = 1'b1;
    cfg_addr  = REG_CTRL;
    cfg_wdata = {{(CFG_W - 2){1'b0}}, mode, en};
    @(posedge clk);
    #DRIVE_DELAY;
    cfg_wr_en = 1'b0;
    // Mode is locked while a vector is open
    if (!model_open) begin
      model_mode = mode;
    end
  endtask

  task automatic read_check(input logic [1:0] addr, input logic [CFG_W-1:0] exp);
    cfg_addr = addr;
    #1;
    check_value("cfg_rdata", cfg_rdata, exp);
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
  endtask

  // Consumer with random stalls
  initial begin
    forever begin
      @(posedge clk);
      #READY_DELAY;
      if (ready_rate < 0) begin
        out_ready = 1'b0;
      end else begin
        out_ready = (rand_bits(ready_rate) == 0);
      end
    end
  end

  // Output transfer completes at the next edge
  always @(negedge clk) begin
    if (UUT.u_props.fail_count != 0) begin
      report_failure("a stream property assertion failed");
    end else if (!rst && out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        report_failure("output transfer with no expected result pending");
      end else begin
        check_value("out_data", out_data, exp_q.pop_front());
        received++;
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > CYCLE_LIMIT) begin
      report_failure("timeout, the run went past its cycle limit");
    end
  end

  initial begin
    lfsr       = 32'h57be1800;
    rst        = 1'b1;
    cfg_wr_en  = 1'b0;
    cfg_addr   = REG_CTRL;
    cfg_wdata  = '0;
    in_valid   = 1'b0;
    in_beat    = '0;
    out_ready  = 1'b0;
    ready_rate = 0;
    model_mode = MODE_DOT;
    model_open = 1'b0;
    model_acc  = 0;
    received   = 0;
    cycles     = 0;
    repeat (5) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;

    // Engine disabled after reset
    read_check(REG_CTRL, 16'h0000);
    in_valid = 1'b1;
    repeat (8) begin
      @(posedge clk);
      #DRIVE_DELAY;
      check_value("in_ready", in_ready, 1'b0);
    end
    in_valid = 1'b0;
    check_value("out_valid", out_valid, 1'b0);

    write_ctrl(1'b1, MODE_DOT);
    repeat (DOT_VECTORS) send_vector();
    wait_drain();

    write_ctrl(1'b1, MODE_PRODUCT);
    repeat (PROD_BEATS) send_beat(rand_bits(1) != 0);
    wait_drain();

    // Stalled consumer, a full FIFO closes the input
    ready_rate = -1;
    repeat (FIFO_DEPTH) send_beat(1'b0);
    repeat (4) @(posedge clk);
    #DRIVE_DELAY;
    check_value("in_ready", in_ready, 1'b0);
    check_value("out_valid", out_valid, 1'b1);
    ready_rate = 3;
    write_ctrl(1'b1, MODE_DOT);
    repeat (BP_VECTORS / 2) send_vector();
    ready_rate = 1;
    repeat (BP_VECTORS / 2) send_vector();
    ready_rate = 0;
    wait_drain();

    // Mode write inside an open vector
    repeat (3) send_beat(1'b0);
    write_ctrl(1'b1, MODE_PRODUCT);
    read_check(REG_CTRL, {{(CFG_W - 2){1'b0}}, model_mode, 1'b1});
    send_beat(1'b1);
    wait_drain();
    read_check(REG_CTRL, {{(CFG_W - 2){1'b0}}, model_mode, 1'b1});
    write_ctrl(1'b1, MODE_PRODUCT);
    read_check(REG_CTRL, {{(CFG_W - 2){1'b0}}, model_mode, 1'b1});

    read_check(REG_COUNT, CFG_W'(received));
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// ==== filelist.f ====
hw/mac_pkg.sv
hw/mac_cfg_regs.sv
hw/mac_sequencer.sv
hw/mac_dsp_slice.sv
hw/result_fifo.sv
hw/mac_stream_top.sv
dv/mac_stream_props.sv
dv/mac_stream_tb.sv

// ==== Makefile ====
# Verilator simulation of the MAC stream engine

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module mac_stream_tb -f filelist.f -Mdir obj_dir
	./obj_dir/Vmac_stream_tb +verilator+error+limit+100 | tee sim.log
	grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
